// File: hdl/fv_info_pkg.sv
// sizes, request, output, load and sram control structs, controller operation enum.
`default_nettype none

package fv_info_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////////////////////////////

    localparam int max_node_id         = 128;                  // graph nodes, table depth.
    localparam int node_id_width       = $clog2(max_node_id);
    localparam int num_edge_pe         = 4;
    localparam int pe_tag_width        = $clog2(num_edge_pe);
    localparam int fv_info_bank_width  = 8;                    // one fv address.

    // covers every request the edge pes can have outstanding.
    localparam int req_fifo_depth      = 16;
    localparam int req_fifo_addr_width = $clog2(req_fifo_depth);

    ////////////////////////////////////////////////////////////////////////////
    // structs
    ////////////////////////////////////////////////////////////////////////////

    // request as it arrives from the bus.
    typedef struct packed {
        logic                     valid;
        logic [node_id_width-1:0] node_id;
        logic [pe_tag_width-1:0]  pe_tag;
    } bus_req_t;

    // one request queue entry.
    typedef struct packed {
        logic [node_id_width-1:0] node_id;
        logic [pe_tag_width-1:0]  pe_tag;
    } fv_req_t;

    // result toward the feature vector FIFO.
    typedef struct packed {
        logic                          valid;
        logic [fv_info_bank_width-1:0] fv_addr;
        logic [pe_tag_width-1:0]       pe_tag;
    } fv_out_t;

    // table write.
    typedef struct packed {
        logic                          valid;
        logic [node_id_width-1:0]      node_id;
        logic [fv_info_bank_width-1:0] fv_addr;
    } table_load_t;

    // sram pins, enables are active low.
    typedef struct packed {
        logic                          cen;
        logic                          wen;
        logic [node_id_width-1:0]      a;
        logic [fv_info_bank_width-1:0] d;
    } sram_ctl_t;

    ////////////////////////////////////////////////////////////////////////////
    // controller operation
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        op_idle,
        op_read,
        op_load
    } cntl_op_e;

endpackage

`default_nettype wire

// File: hdl/fv_info_sync_fifo.sv
// synchronous request queue of node id and pe tag pairs with full and empty flags.
`default_nettype none
`timescale 1ns/100ps

module fv_info_sync_fifo (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 winc,
    input  fv_info_pkg::fv_req_t wdata,
    input  logic                 rinc,
    output fv_info_pkg::fv_req_t rdata,
    output logic                 wfull,
    output logic                 rempty
);

    import fv_info_pkg::*;

    fv_req_t                      mem [req_fifo_depth];
    logic [req_fifo_addr_width:0] wptr;   // extra msb tells full from empty.
    logic [req_fifo_addr_width:0] rptr;
    logic                         do_write;
    logic                         do_read;

    assign do_write = winc && !wfull;
    assign do_read  = rinc && !rempty;

    ////////////////////////////////////////////////////////////////////////////
    // pointers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            wptr <= '0;
            rptr <= '0;
        end else begin
            if (do_write)
                wptr <= wptr + 1'b1;
            if (do_read)
                rptr <= rptr + 1'b1;
        end
    end

    // storage.
    always_ff @(posedge clk) begin
        if (do_write)
            mem[wptr[req_fifo_addr_width-1:0]] <= wdata;
    end

    assign rdata  = mem[rptr[req_fifo_addr_width-1:0]];     // head entry, always shown.
    assign rempty = (wptr == rptr);
    assign wfull  = (wptr[req_fifo_addr_width] != rptr[req_fifo_addr_width]) &&
                    (wptr[req_fifo_addr_width-1:0] == rptr[req_fifo_addr_width-1:0]);

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    // the bus traffic limit must keep the queue from overflowing.
    a_no_write_when_full: assert property (
        @(posedge clk) disable iff (reset)
        winc |-> !wfull
    ) else $error("request queue written while full");

    // the controller must only pop a valid head.
    a_no_read_when_empty: assert property (
        @(posedge clk) disable iff (reset)
        rinc |-> !rempty
    ) else $error("request queue popped while empty");

endmodule

`default_nettype wire

// File: hdl/fv_info_sram.sv
// behavioral single port table sram with active low enables and registered read.
`default_nettype none
`timescale 1ns/100ps

module fv_info_sram (
    input  logic                                     clk,
    input  fv_info_pkg::sram_ctl_t                   ctl,
    output logic [fv_info_pkg::fv_info_bank_width-1:0] q
);

    import fv_info_pkg::*;

    logic [fv_info_bank_width-1:0] mem [max_node_id];   // contents survive reset.

    // macro pin behavior.
    // cen low and wen low writes d at a.
    // cen low and wen high registers the word at a into q.
    always_ff @(posedge clk) begin
        if (!ctl.cen) begin
            if (!ctl.wen)
                mem[ctl.a] <= ctl.d;
            else
                q <= mem[ctl.a];        // q holds its value otherwise.
        end
    end

endmodule

`default_nettype wire

// File: hdl/fv_info_mem_cntl.sv
// memory controller that arbitrates table loads and lookups and forms the fv output.
`default_nettype none
`timescale 1ns/100ps

module fv_info_mem_cntl (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic                                        empty,
    input  fv_info_pkg::fv_req_t                        head,
    input  logic                                        fv_fifo_full,
    input  fv_info_pkg::table_load_t                    table_load,
    input  logic [fv_info_pkg::fv_info_bank_width-1:0]  sram_q,
    output logic                                        rinc,
    output fv_info_pkg::sram_ctl_t                      sram_ctl,
    output fv_info_pkg::fv_out_t                        fv_out
);

    import fv_info_pkg::*;

    cntl_op_e                op;
    logic                    rd_pend;   // read issued last cycle.
    logic [pe_tag_width-1:0] tag_q;     // tag of the entry in the sram stage.

    ////////////////////////////////////////////////////////////////////////////
    // arbitration
    ////////////////////////////////////////////////////////////////////////////

    // a load wins the cycle and a lookup needs a head entry and room downstream.
    always_comb begin
        if (table_load.valid)
            op = op_load;
        else if (!empty && !fv_fifo_full)
            op = op_read;
        else
            op = op_idle;
    end

    assign rinc = (op == op_read);  // pop in the same cycle as the read.

    ////////////////////////////////////////////////////////////////////////////
    // sram drive
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        sram_ctl = '{cen: 1'b1, wen: 1'b1, a: '0, d: '0};
        case (op)
            op_load: begin
                sram_ctl.cen = 1'b0;
                sram_ctl.wen = 1'b0;
                sram_ctl.a   = table_load.node_id;
                sram_ctl.d   = table_load.fv_addr;
            end
            op_read: begin
                sram_ctl.cen = 1'b0;
                sram_ctl.a   = head.node_id;   // wen stays high.
            end
            default: begin
                sram_ctl.cen = 1'b1;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // sram stage
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset)
            rd_pend <= 1'b0;
        else
            rd_pend <= (op == op_read);
    end

    always_ff @(posedge clk) begin
        if (op == op_read)
            tag_q <= head.pe_tag;
    end

    // data and tag line up one cycle after the read.
    assign fv_out = '{valid: rd_pend, fv_addr: sram_q, pe_tag: tag_q};

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    // a pop is a read of the head at the sram pins with room downstream.
    a_pop_allowed: assert property (
        @(posedge clk) disable iff (reset)
        rinc |-> (!fv_fifo_full && !empty && !sram_ctl.cen && sram_ctl.wen)
    ) else $error("pop issued while fv fifo full, queue empty or without an sram read");

    // every result comes from a read at the sram pins the cycle before.
    a_valid_after_read: assert property (
        @(posedge clk) disable iff (reset)
        fv_out.valid |-> $past(!sram_ctl.cen && sram_ctl.wen)
    ) else $error("fv_out valid without an sram read in the previous cycle");

endmodule

`default_nettype wire

// File: hdl/fv_info_integration.sv
// top level connecting the request queue, the memory controller and the table sram.
`default_nettype none
`timescale 1ns/100ps

module fv_info_integration (
    input  logic                     clk,
    input  logic                     reset,
    input  fv_info_pkg::bus_req_t    bus_req,
    input  logic                     fv_fifo_full,
    input  fv_info_pkg::table_load_t table_load,
    output fv_info_pkg::fv_out_t     fv_out
);

    import fv_info_pkg::*;

    fv_req_t                       fifo_wdata;
    fv_req_t                       fifo_head;
    logic                          fifo_empty;
    logic                          fifo_rinc;
    sram_ctl_t                     sram_ctl;
    logic [fv_info_bank_width-1:0] sram_q;

    // queue entry drops the valid bit, which becomes the write strobe.
    assign fifo_wdata = '{node_id: bus_req.node_id, pe_tag: bus_req.pe_tag};

    ////////////////////////////////////////////////////////////////////////////
    // request queue
    ////////////////////////////////////////////////////////////////////////////

    fv_info_sync_fifo fifo0 (
        .clk    (clk),
        .reset  (reset),
        .winc   (bus_req.valid),
        .wdata  (fifo_wdata),
        .rinc   (fifo_rinc),
        .rdata  (fifo_head),
        .wfull  (),             // depth covers all pe requests, checked inside.
        .rempty (fifo_empty)
    );

    ////////////////////////////////////////////////////////////////////////////
    // controller and table
    ////////////////////////////////////////////////////////////////////////////

    fv_info_mem_cntl mem_cntl0 (
        .clk          (clk),
        .reset        (reset),
        .empty        (fifo_empty),
        .head         (fifo_head),
        .fv_fifo_full (fv_fifo_full),
        .table_load   (table_load),
        .sram_q       (sram_q),
        .rinc         (fifo_rinc),
        .sram_ctl     (sram_ctl),
        .fv_out       (fv_out)
    );

    // 8 bits wide, 128 deep.
    fv_info_sram sram0 (
        .clk (clk),
        .ctl (sram_ctl),
        .q   (sram_q)
    );

endmodule

`default_nettype wire

// File: verif/fv_info_integration_tb.sv
// fv info lookup testbench with clock, reset, stimulus, reference model and assertions.
`default_nettype none
`timescale 1ns/100ps

module fv_info_integration_tb;

    import fv_info_pkg::*;

    localparam int clk_period     = 40;
    localparam int drain_timeout  = 2000;   // cycles.
    localparam int stream_timeout = 4000;

    // expected result and the node id that frees its entry on arrival.
    typedef struct packed {
        logic [node_id_width-1:0]      node_id;
        logic [fv_info_bank_width-1:0] fv_addr;
        logic [pe_tag_width-1:0]       pe_tag;
    } exp_item_t;

    logic        clk = 1'b0;
    logic        reset;
    bus_req_t    bus_req;
    logic        fv_fifo_full;
    table_load_t table_load;
    fv_out_t     fv_out;

    logic [31:0] rng_state = 32'h88c4_ce7a;
    logic        quiet = 1'b0;                      // no result may appear.

    logic [fv_info_bank_width-1:0] shadow [max_node_id];
    int        sent_cnt [max_node_id];
    int        recv_cnt [max_node_id];
    exp_item_t exp_mem [256];
    int        exp_wr;
    int        exp_rd;
    int        exp_cnt;
    exp_item_t exp_head;

    int fail_count;
    int tests_run;
    int tests_failed;
    int results_seen;

    assign exp_cnt  = exp_wr - exp_rd;              // sent but not yet received.
    assign exp_head = exp_mem[exp_rd[7:0]];

    fv_info_integration dut0 (
        .clk          (clk),
        .reset        (reset),
        .bus_req      (bus_req),
        .fv_fifo_full (fv_fifo_full),
        .table_load   (table_load),
        .fv_out       (fv_out)
    );

    initial begin
        forever #(clk_period / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // retire the head of the expected queue on every result.
    always @(posedge clk) begin
        if (!reset && fv_out.valid && exp_cnt != 0) begin
            recv_cnt[exp_head.node_id] <= recv_cnt[exp_head.node_id] + 1;
            exp_rd       <= exp_rd + 1;
            results_seen <= results_seen + 1;
        end
    end

    // a node with nothing outstanding may be rewritten.
    function automatic logic [node_id_width-1:0] pick_free_node();
        logic [31:0]              r;
        logic [node_id_width-1:0] node;
        r    = next_rand();
        node = r[31 -: node_id_width];
        for (int i = 0; i < max_node_id; i++) begin
            if (sent_cnt[node] == recv_cnt[node])
                return node;
            node = node + 1'b1;
        end
        return node;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    a_no_early_result: assert property (
        @(posedge clk) disable iff (reset) quiet |-> !fv_out.valid
    ) else begin
        fail_count++;
        $display("%0t: fv_out.valid went high before any request was sent", $time);
    end

    a_result_expected: assert property (
        @(posedge clk) disable iff (reset) fv_out.valid |-> exp_cnt != 0
    ) else begin
        fail_count++;
        $display("%0t: fv_out.valid high with no request outstanding", $time);
    end

    a_fv_addr_match: assert property (
        @(posedge clk) disable iff (reset)
        (fv_out.valid && exp_cnt != 0) |-> fv_out.fv_addr == exp_head.fv_addr
    ) else begin
        fail_count++;
        $display("error at %0t: fv_out.fv_addr expected %h actual %h", $time,
                 $sampled(exp_head.fv_addr), $sampled(fv_out.fv_addr));
    end

    a_pe_tag_match: assert property (
        @(posedge clk) disable iff (reset)
        (fv_out.valid && exp_cnt != 0) |-> fv_out.pe_tag == exp_head.pe_tag
    ) else begin
        fail_count++;
        $display("error at %0t: fv_out.pe_tag expected %h actual %h", $time,
                 $sampled(exp_head.pe_tag), $sampled(fv_out.pe_tag));
    end

    // one result read before full was seen may still come out.
    a_full_stall: assert property (
        @(posedge clk) disable iff (reset) $past(fv_fifo_full) |-> !fv_out.valid
    ) else begin
        fail_count++;
        $display("%0t: result appeared more than one cycle into fv_fifo_full", $time);
    end

    a_load_stall: assert property (
        @(posedge clk) disable iff (reset) $past(table_load.valid) |-> !fv_out.valid
    ) else begin
        fail_count++;
        $display("%0t: result appeared more than one cycle into a table load", $time);
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus tasks called right after a falling edge
    ////////////////////////////////////////////////////////////////////////////

    task automatic drive_request(input logic [node_id_width-1:0] node,
                                 input logic [pe_tag_width-1:0]  tag);
        exp_item_t item;
        item = '{node_id: node, fv_addr: shadow[node], pe_tag: tag};
        exp_mem[exp_wr[7:0]] = item;
        exp_wr = exp_wr + 1;
        sent_cnt[node] = sent_cnt[node] + 1;
        bus_req = '{valid: 1'b1, node_id: node, pe_tag: tag};
    endtask

    task automatic drive_load(input logic [node_id_width-1:0]      node,
                              input logic [fv_info_bank_width-1:0] value);
        shadow[node] = value;
        table_load = '{valid: 1'b1, node_id: node, fv_addr: value};
    endtask

    task automatic wait_drain(input string what);
        int cycles;
        cycles = 0;
        while (exp_cnt != 0 && cycles < drain_timeout) begin
            @(negedge clk);
            cycles++;
        end
        if (exp_cnt != 0) begin
            fail_count++;
            $display("%0t: timed out in %s with %0d results still missing", $time, what,
                     exp_cnt);
        end
    endtask

    // back to back requests with full toggled in random stretches when asked.
    task automatic run_stream(input int n_req, input bit pulse_full);
        int          sent;
        int          cycles;
        int          stretch;
        logic [31:0] r;
        sent    = 0;
        cycles  = 0;
        stretch = 0;
        while (sent < n_req && cycles < stream_timeout) begin
            @(negedge clk);
            cycles++;
            bus_req.valid = 1'b0;
            if (pulse_full) begin
                if (stretch == 0) begin
                    r = next_rand();
                    fv_fifo_full = !fv_fifo_full;
                    stretch = 1 + int'(r[27:24]);
                end
                stretch--;
            end
            if (exp_cnt < req_fifo_depth) begin
                r = next_rand();
                drive_request(r[31 -: node_id_width], r[23 -: pe_tag_width]);
                sent++;
            end
        end
        if (sent < n_req) begin
            fail_count++;
            $display("%0t: stream stalled after %0d of %0d requests", $time, sent, n_req);
        end
        @(negedge clk);
        bus_req.valid = 1'b0;
        fv_fifo_full  = 1'b0;
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (fail_count == errors_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, fail_count - errors_before);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0]              r;
        int                       errs;
        logic [node_id_width-1:0] rewritten [8];
        reset        = 1'b1;
        bus_req      = '0;
        table_load   = '0;
        fv_fifo_full = 1'b0;
        repeat (4) @(negedge clk);
        reset = 1'b0;

        errs  = fail_count;
        quiet = 1'b1;
        repeat (10) @(negedge clk);
        quiet = 1'b0;
        finish_test("idle after reset", errs);

        errs = fail_count;
        for (int i = 0; i < max_node_id; i++) begin
            @(negedge clk);
            r = next_rand();
            drive_load(i[node_id_width-1:0], r[31:24]);
        end
        @(negedge clk);
        table_load.valid = 1'b0;
        for (int k = 0; k < 12; k++) begin
            @(negedge clk);
            r = next_rand();
            drive_request(r[31 -: node_id_width], r[23 -: pe_tag_width]);
            @(negedge clk);
            bus_req.valid = 1'b0;
            wait_drain("single lookup");
        end
        finish_test("table lookup", errs);

        errs = fail_count;
        run_stream(64, 1'b0);
        wait_drain("request stream");
        finish_test("ordering under a stream", errs);

        errs = fail_count;
        run_stream(64, 1'b1);
        wait_drain("back-pressure");
        finish_test("back-pressure", errs);

        // requests pile up in the queue behind the held load.
        errs = fail_count;
        for (int k = 0; k < 10; k++) begin
            @(negedge clk);
            bus_req.valid = 1'b0;
            if (k < 8) begin
                r = next_rand();
                drive_request(r[31 -: node_id_width], r[23 -: pe_tag_width]);
            end
            r = next_rand();
            drive_load(pick_free_node(), r[31:24]);
        end
        @(negedge clk);
        table_load.valid = 1'b0;
        wait_drain("load priority");
        finish_test("load priority", errs);

        errs = fail_count;
        for (int k = 0; k < 8; k++) begin
            @(negedge clk);
            r = next_rand();
            rewritten[k] = r[31 -: node_id_width];
            drive_load(rewritten[k], ~shadow[rewritten[k]]);   // always a new value.
        end
        @(negedge clk);
        table_load.valid = 1'b0;
        for (int k = 0; k < 8; k++) begin
            @(negedge clk);
            r = next_rand();
            drive_request(rewritten[k], r[23 -: pe_tag_width]);
        end
        @(negedge clk);
        bus_req.valid = 1'b0;
        wait_drain("table rewrite");
        finish_test("table rewrite", errs);

        repeat (4) @(negedge clk);
        $display("tests run %0d, tests failed %0d, errors %0d, results checked %0d",
                 tests_run, tests_failed, fail_count, results_seen);
        if (fail_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
hdl/fv_info_pkg.sv
hdl/fv_info_sync_fifo.sv
hdl/fv_info_sram.sv
hdl/fv_info_mem_cntl.sv
hdl/fv_info_integration.sv
verif/fv_info_integration_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the fv info testbench, then look for the pass line in the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module fv_info_integration_tb -o fv_info_sim \
    && ./obj_dir/fv_info_sim > sim.log 2>&1 \
    || echo "build or simulation did not complete"

cat sim.log 2>/dev/null
grep -qx "TESTBENCH PASSED" sim.log 2>/dev/null && echo "run passed" \
    || { echo "run failed"; exit 1; }
